// File: all.f
line_pkg.sv
line_setup.sv
bresenham_stepper.sv
pixel_burst_writer.sv
line_engine_top.sv
line_engine_assertions.sv
tb_line_engine.sv

// File: run_sim.sh
#!/bin/sh
# build with verilator, run, and look for the pass line in the output
cd "$(dirname "$0")" &&
  verilator --binary --timing --assert --top-module tb_line_engine -f all.f -o tb_line_engine &&
  ./obj_dir/tb_line_engine +verilator+error+limit+100 | tee /dev/stderr |
  grep -x "sim passed" > /dev/null &&
  echo "PASS" || { echo "FAIL"; exit 1; }

// File: tb_line_engine.sv
`timescale 1ns/1ns
`default_nettype none

module tb_line_engine;

  import line_pkg::*;

  localparam int timeout_cycles = 20000;
  localparam int burst_w        = addr_w + 2 * mask_w;

  logic clk = 1'b0;
  logic rst, color_valid, point0_valid, point1_valid, trigger, af_full, wdf_full;
  logic ready, af_wr_en, wdf_wr_en;
  logic [color_w-1:0]      color, cur_color;
  logic [point_w-1:0]      point;
  logic [frame_base_w-1:0] frame_base;
  logic [addr_w-1:0]       af_addr_din, beat_addr;
  logic [data_w-1:0]       wdf_din;
  logic [mask_w-1:0]       wdf_mask_din, beat_mask;
  logic [burst_w-1:0]      got[$];
  logic [burst_w-1:0]      exp_q[$];
  logic [31:0] seed = 32'h4e38_fb3d;
  logic bp_on = 1'b0;
  logic hung = 1'b0;
  int errors = 0;
  int sink_errors = 0;
  int tests = 0;
  int failed_tests = 0;
  int mark = 0;
  int base = 0;
  string test_name = "reset_idle";

  line_engine_top u_line_engine (.*);

  always #2 clk = ~clk;

  // FIFO sink samples mid-cycle where enables and data have settled
  always @(negedge clk) begin
    if (!rst) begin
      assert (!((af_wr_en || wdf_wr_en) && (af_full || wdf_full))) else begin
        $display("%s: beat issued while a FIFO was full", test_name);
        sink_errors++;
      end
      if (wdf_wr_en) begin
        assert (wdf_din == {4{cur_color}}) else begin
          $display("Fail %s: wdf_din expected %h, actual %h", test_name, {4{cur_color}}, wdf_din);
          sink_errors++;
        end
        if (af_wr_en) begin
          beat_addr = af_addr_din;
          beat_mask = wdf_mask_din;
        end else begin
          got.push_back({beat_addr, beat_mask, wdf_mask_din});
        end
      end
    end
  end

  function automatic logic [31:0] xorshift(input logic [31:0] s);
    logic [31:0] x;
    x = s ^ (s << 13);
    x = x ^ (x >> 17);
    return x ^ (x << 5);
  endfunction

  function automatic int abs_i(input int v);
    return (v < 0) ? -v : v;
  endfunction

  // lanes 0 to 3 sit in beat 1 (upper half), lanes 4 to 7 in beat 2
  function automatic logic [2*mask_w-1:0] burst_mask(input logic [2:0] c);
    logic [2*mask_w-1:0] m;
    int p;
    m = '1;
    p = {29'd0, c};
    m[31 - 4 * p -: 4] = 4'h0;
    return m;
  endfunction

  function automatic int error_total();
    return errors + sink_errors + u_line_engine.u_writer.u_assertions.fail_count;
  endfunction

  task automatic step();
    @(posedge clk);
    #1;
    if (bp_on) begin
      seed = xorshift(seed);
      af_full = seed[3] & seed[7];
      wdf_full = seed[12] & seed[19];
    end else begin
      af_full = 1'b0;
      wdf_full = 1'b0;
    end
  endtask

  task automatic clear_strobes();
    color_valid = 1'b0;
    point0_valid = 1'b0;
    point1_valid = 1'b0;
    trigger = 1'b0;
  endtask

  task automatic load_line(input logic [point_w-1:0] p0, input logic [point_w-1:0] p1,
                           input logic [color_w-1:0] col, input logic [frame_base_w-1:0] fb);
    step();
    color = col;
    color_valid = 1'b1;
    point = p0;
    point0_valid = 1'b1;
    frame_base = fb;
    step();
    clear_strobes();
    point = p1;
    point1_valid = 1'b1;
    step();
    clear_strobes();
    cur_color = col;
  endtask

  // expected bursts straight from the Bresenham rules
  task automatic ref_line(input logic [point_w-1:0] p0, input logic [point_w-1:0] p1,
                          input logic [frame_base_w-1:0] fb);
    int x0, y0, x1, y1, t, dxv, dyv, err, y, ystep, x;
    logic steep;
    logic [coord_w-1:0] row, col;
    x0 = {22'd0, p0[19:10]};
    y0 = {22'd0, p0[9:0]};
    x1 = {22'd0, p1[19:10]};
    y1 = {22'd0, p1[9:0]};
    steep = abs_i(y1 - y0) > abs_i(x1 - x0);
    if (steep) begin
      t = x0;
      x0 = y0;
      y0 = t;
      t = x1;
      x1 = y1;
      y1 = t;
    end
    if (x0 > x1) begin
      t = x0;
      x0 = x1;
      x1 = t;
      t = y0;
      y0 = y1;
      y1 = t;
    end
    dxv = x1 - x0;
    dyv = abs_i(y1 - y0);
    ystep = (y1 >= y0) ? 1 : -1;
    err = dxv / 2;
    y = y0;
    for (x = x0; x <= x1; x++) begin
      row = steep ? y[9:0] : x[9:0];
      col = steep ? x[9:0] : y[9:0];
      exp_q.push_back({6'd0, fb[27:22], row, col[9:3], 2'd0, burst_mask(col[2:0])});
      err = err - dyv;
      if (err < 0) begin
        y = y + ystep;
        err = err + dxv;
      end
    end
  endtask

  task automatic launch();
    base = got.size();
    step();
    trigger = 1'b1;
    step();
    trigger = 1'b0;
    assert (!ready) else begin
      $display("%s: ready stayed high after an accepted trigger", test_name);
      errors++;
    end
  endtask

  task automatic await_idle();
    int n;
    n = 0;
    while (!ready && !hung) begin
      step();
      n++;
      if (n >= timeout_cycles) begin
        $display("%s: ready did not return within %0d cycles", test_name, timeout_cycles);
        errors++;
        hung = 1'b1;
      end
    end
  endtask

  task automatic compare();
    int n, i;
    n = got.size() - base;
    assert (n == exp_q.size()) else begin
      $display("Fail %s: pixel count expected %0d, actual %0d", test_name, exp_q.size(), n);
      errors++;
    end
    for (i = 0; i < n && i < exp_q.size(); i++) begin
      assert (got[base + i] == exp_q[i]) else begin
        $display("Fail %s: pixel %0d expected %h, actual %h", test_name, i, exp_q[i],
                 got[base + i]);
        errors++;
      end
    end
    exp_q.delete();
  endtask

  task automatic run_line(input logic [point_w-1:0] p0, input logic [point_w-1:0] p1,
                          input logic [color_w-1:0] col, input logic [frame_base_w-1:0] fb);
    load_line(p0, p1, col, fb);
    ref_line(p0, p1, fb);
    launch();
    await_idle();
    compare();
  endtask

  task automatic begin_test(input string name);
    test_name = name;
    mark = error_total();
  endtask

  task automatic finish_test();
    tests++;
    if (error_total() == mark) begin
      $display("test %s passed", test_name);
    end else begin
      failed_tests++;
      $display("test %s failed with %0d errors", test_name, error_total() - mark);
    end
  endtask

  initial begin
    int i;
    logic [point_w-1:0] pa, pb;
    rst = 1'b1;
    color = '0;
    cur_color = '0;
    point = '0;
    frame_base = '0;
    af_full = 1'b0;
    wdf_full = 1'b0;
    clear_strobes();
    for (i = 0; i < 14; i++) begin
      step();
      rst = (i < 9);
      assert (ready && !af_wr_en && !wdf_wr_en) else begin
        $display("%s: DUT not idle in or just after reset", test_name);
        errors++;
      end
    end
    finish_test();

    begin_test("shallow_line");
    run_line({10'd12, 10'd100}, {10'd47, 10'd113}, 32'h0012_3456, 32'h0440_0000);
    finish_test();

    begin_test("steep_reversed");
    run_line({10'd300, 10'd400}, {10'd290, 10'd350}, 32'h00fe_dcba, 32'h0180_0000);
    finish_test();

    begin_test("random_backpressure");
    bp_on = 1'b1;
    for (i = 0; i < 6; i++) begin
      seed = xorshift(seed);
      pa = {1'b0, seed[18:10], 1'b0, seed[8:0]};
      seed = xorshift(seed);
      pb = {1'b0, seed[18:10], 1'b0, seed[8:0]};
      run_line(pa, pb, {8'h00, seed[31:8]}, seed);
    end
    bp_on = 1'b0;
    finish_test();

    // junk in every field outside bits 27 to 22
    begin_test("colour_frame");
    run_line({10'd700, 10'd5}, {10'd709, 10'd1}, 32'h00a1_b2c3, 32'hfb7f_ffff);
    finish_test();

    begin_test("ready_lockout");
    pa = {10'd500, 10'd20};
    pb = {10'd530, 10'd41};
    load_line(pa, pb, 32'h0055_aa11, 32'h0a00_0000);
    ref_line(pa, pb, 32'h0a00_0000);
    launch();
    step();
    point = {10'd1, 10'd2};
    point0_valid = 1'b1;
    point1_valid = 1'b1;
    color = 32'h00ff_ffff;
    color_valid = 1'b1;
    trigger = 1'b1;
    step();
    clear_strobes();
    await_idle();
    compare();
    base = got.size();
    for (i = 0; i < 6; i++) begin
      step();
    end
    assert (ready && got.size() == base) else begin
      $display("%s: a trigger given while busy started another line", test_name);
      errors++;
    end
    // relaunch with the stored endpoints
    ref_line(pa, pb, 32'h0a00_0000);
    launch();
    await_idle();
    compare();
    finish_test();

    $display("tests %0d, failed %0d, errors %0d", tests, failed_tests, error_total());
    if (error_total() == 0 && failed_tests == 0 && !hung) begin
      $display("sim passed");
    end else begin
      $display("sim failed");
    end
    $finish;
  end

endmodule

`default_nettype wire

// File: line_engine_assertions.sv
`timescale 1ns/1ns
`default_nettype none

module line_engine_assertions (
  input logic                        clk,
  input logic                        rst,
  input logic                        af_wr_en,
  input logic                        wdf_wr_en,
  input logic                        af_full,
  input logic                        wdf_full,
  input logic [line_pkg::mask_w-1:0] wdf_mask_din
);

  import line_pkg::*;

  int                  fail_count = 0;
  logic                pending;
  logic [mask_w-1:0]   mask1_q;
  logic [2*mask_w-1:0] cleared;
  logic                one_nibble;

  // pending means a beat 1 went out and its beat 2 has not
  always_ff @(posedge clk) begin
    if (rst) begin
      pending <= 1'b0;
    end else if (wdf_wr_en) begin
      pending <= af_wr_en;
    end
    if (af_wr_en) begin
      mask1_q <= wdf_mask_din;
    end
  end

  // enabled bytes over both beats of the burst
  assign cleared = ~{mask1_q, wdf_mask_din};

  always_comb begin
    one_nibble = 1'b0;
    for (int i = 0; i < burst_pixels; i++) begin
      if (cleared == ({{(2 * mask_w - nibble_w){1'b0}}, {nibble_w{1'b1}}} << (nibble_w * i))) begin
        one_nibble = 1'b1;
      end
    end
  end

  a_af_with_wdf: assert property (@(posedge clk) disable iff (rst) af_wr_en |-> wdf_wr_en)
    else begin
      $error("address write without a data write");
      fail_count++;
    end

  a_beat_order: assert property (@(posedge clk) disable iff (rst)
    wdf_wr_en |-> (af_wr_en == !pending))
    else begin
      $error("beat 1 and beat 2 out of order");
      fail_count++;
    end

  a_no_write_when_full: assert property (@(posedge clk) disable iff (rst)
    (af_wr_en || wdf_wr_en) |-> !(af_full || wdf_full))
    else begin
      $error("write enable raised while a FIFO is full");
      fail_count++;
    end

  a_one_pixel: assert property (@(posedge clk) disable iff (rst)
    (wdf_wr_en && !af_wr_en) |-> one_nibble)
    else begin
      $error("burst mask does not enable exactly one pixel");
      fail_count++;
    end

endmodule

bind pixel_burst_writer line_engine_assertions u_assertions (.*);

`default_nettype wire

// File: line_engine_top.sv
`timescale 1ns/1ns
`default_nettype none

module line_engine_top (
  input  logic                                clk,
  input  logic                                rst,
  input  logic [line_pkg::color_w-1:0]        color,
  input  logic [line_pkg::point_w-1:0]        point,
  input  logic                                color_valid,
  input  logic                                point0_valid,
  input  logic                                point1_valid,
  input  logic                                trigger,
  input  logic [line_pkg::frame_base_w-1:0]   frame_base,
  input  logic                                af_full,
  input  logic                                wdf_full,
  output logic                                ready,
  output logic [line_pkg::addr_w-1:0]         af_addr_din,
  output logic                                af_wr_en,
  output logic [line_pkg::data_w-1:0]         wdf_din,
  output logic [line_pkg::mask_w-1:0]         wdf_mask_din,
  output logic                                wdf_wr_en
);

  import line_pkg::*;

  // setup to stepper
  logic                   start;
  logic                   steep;
  logic [coord_w-1:0]     x_start;
  logic [coord_w-1:0]     x_end;
  logic [coord_w-1:0]     y_start;
  logic [err_w-1:0]       dx;
  logic [err_w-1:0]       abs_dy;
  logic                   y_up;

  // setup to writer
  logic [color_w-1:0]     pixel_color;
  logic [frame_sel_w-1:0] frame_sel;

  // stepper to writer
  logic                   pixel_valid;
  logic [coord_w-1:0]     row;
  logic [coord_w-1:0]     col;
  logic                   take;

  // busy levels back to setup
  logic                   stepper_busy;
  logic                   writer_busy;

  line_setup u_setup (.*);

  bresenham_stepper u_stepper (.*, .busy(stepper_busy));

  pixel_burst_writer u_writer (.*, .busy(writer_busy));

endmodule

`default_nettype wire

// File: pixel_burst_writer.sv
`timescale 1ns/1ns
`default_nettype none

module pixel_burst_writer (
  input  logic                               clk,
  input  logic                               rst,
  input  logic                               pixel_valid,
  input  logic [line_pkg::coord_w-1:0]       row,
  input  logic [line_pkg::coord_w-1:0]       col,
  input  logic [line_pkg::color_w-1:0]       pixel_color,
  input  logic [line_pkg::frame_sel_w-1:0]   frame_sel,
  input  logic                               af_full,
  input  logic                               wdf_full,
  output logic                               take,
  output logic                               busy,
  output logic [line_pkg::addr_w-1:0]        af_addr_din,
  output logic                               af_wr_en,
  output logic [line_pkg::data_w-1:0]        wdf_din,
  output logic [line_pkg::mask_w-1:0]        wdf_mask_din,
  output logic                               wdf_wr_en
);

  import line_pkg::*;

  // one-entry pixel register plus beat sequencer
  logic                    held;
  logic                    beat2;
  logic [coord_w-1:0]      row_q;
  logic [coord_w-1:0]      col_q;
  logic                    go;
  logic [lane_sel_w-1:0]   lane;
  logic [lane_sel_w-2:0]   slot;
  logic                    lane_hit;

  // a beat needs room in both fifos
  assign go = !af_full && !wdf_full;

  // load when empty, or in the same cycle as the outgoing beat 2
  assign take = pixel_valid && (!held || (beat2 && go));
  assign busy = held;

  always_ff @(posedge clk) begin
    if (rst) begin
      held  <= 1'b0;
      beat2 <= 1'b0;
    end else if (take) begin
      held  <= 1'b1;
      beat2 <= 1'b0;
    end else if (held && go) begin
      if (beat2) begin
        held  <= 1'b0;
        beat2 <= 1'b0;
      end else begin
        beat2 <= 1'b1;
      end
    end
  end

  always_ff @(posedge clk) begin
    if (take) begin
      row_q <= row;
      col_q <= col;
    end
  end

  // beat 1 carries the address, beat 2 only data
  assign af_wr_en  = held && !beat2 && go;
  assign wdf_wr_en = held && go;

  // burst address, column in units of 8 pixels
  assign af_addr_din = {
    {addr_pad_w{1'b0}},
    frame_sel,
    row_q,
    col_q[coord_w-1:lane_sel_w],
    {addr_lo_w{1'b0}}
  };

  // same colour in all four lanes, the mask picks the real one
  assign wdf_din = {beat_pixels{pixel_color}};

  // lane msb says which beat holds the pixel
  assign lane     = col_q[lane_sel_w-1:0];
  assign slot     = lane[lane_sel_w-2:0];
  assign lane_hit = (lane[lane_sel_w-1] == beat2);

  // pixel p owns mask bits 15-4p down to 12-4p, a 1 disables a byte
  always_comb begin
    if (lane_hit) begin
      wdf_mask_din = ~({{nibble_w{1'b1}}, {(mask_w - nibble_w){1'b0}}} >> (nibble_w * slot));
    end else begin
      wdf_mask_din = {mask_w{1'b1}};
    end
  end

endmodule

`default_nettype wire

// File: bresenham_stepper.sv
`timescale 1ns/1ns
`default_nettype none

module bresenham_stepper (
  input  logic                           clk,
  input  logic                           rst,
  input  logic                           start,
  input  logic                           steep,
  input  logic [line_pkg::coord_w-1:0]   x_start,
  input  logic [line_pkg::coord_w-1:0]   x_end,
  input  logic [line_pkg::coord_w-1:0]   y_start,
  input  logic [line_pkg::err_w-1:0]     dx,
  input  logic [line_pkg::err_w-1:0]     abs_dy,
  input  logic                           y_up,
  input  logic                           take,
  output logic                           pixel_valid,
  output logic [line_pkg::coord_w-1:0]   row,
  output logic [line_pkg::coord_w-1:0]   col,
  output logic                           busy
);

  import line_pkg::*;

  // sx is the major coordinate, sy the minor one
  logic [coord_w-1:0]      sx;
  logic [coord_w-1:0]      sy;
  logic signed [err_w-1:0] err;
  logic signed [err_w-1:0] err_dec;
  logic signed [err_w-1:0] err_init;
  logic                    last;
  logic                    advance;

  // line fields stay put in line_setup until the next launch,
  // which cannot happen while this stage is busy

  // error starts at dx/2, rounded down
  assign err_init = $signed(dx >> 1);
  assign err_dec  = err - $signed(abs_dy);
  assign last     = (sx == x_end);
  assign advance  = take && !last;

  always_ff @(posedge clk) begin
    if (rst) begin
      busy <= 1'b0;
    end else if (start) begin
      busy <= 1'b1;
    end else if (take && last) begin
      // x_end just went to the writer
      busy <= 1'b0;
    end
  end

  always_ff @(posedge clk) begin
    if (start) begin
      sx  <= x_start;
      sy  <= y_start;
      err <= err_init;
    end else if (advance) begin
      sx <= sx + 1'b1;
      if (err_dec < 0) begin
        // minor axis step
        if (y_up) begin
          sy <= sy + 1'b1;
        end else begin
          sy <= sy - 1'b1;
        end
        err <= err_dec + $signed(dx);
      end else begin
        err <= err_dec;
      end
    end
  end

  // the current pixel is offered for as long as the walk runs
  assign pixel_valid = busy;

  // undo the steep swap
  assign row = steep ? sy : sx;
  assign col = steep ? sx : sy;

endmodule

`default_nettype wire

// File: line_setup.sv
`timescale 1ns/1ns
`default_nettype none

module line_setup (
  input  logic                                clk,
  input  logic                                rst,
  input  logic [line_pkg::color_w-1:0]        color,
  input  logic [line_pkg::point_w-1:0]        point,
  input  logic                                color_valid,
  input  logic                                point0_valid,
  input  logic                                point1_valid,
  input  logic                                trigger,
  input  logic [line_pkg::frame_base_w-1:0]   frame_base,
  input  logic                                stepper_busy,
  input  logic                                writer_busy,
  output logic                                ready,
  output logic                                start,
  output logic                                steep,
  output logic [line_pkg::coord_w-1:0]        x_start,
  output logic [line_pkg::coord_w-1:0]        x_end,
  output logic [line_pkg::coord_w-1:0]        y_start,
  output logic [line_pkg::err_w-1:0]          dx,
  output logic [line_pkg::err_w-1:0]          abs_dy,
  output logic                                y_up,
  output logic [line_pkg::color_w-1:0]        pixel_color,
  output logic [line_pkg::frame_sel_w-1:0]    frame_sel
);

  import line_pkg::*;

  logic [point_w-1:0] p0_q;
  logic [point_w-1:0] p1_q;
  logic [point_w-1:0] p0_n;
  logic [point_w-1:0] p1_n;
  logic [coord_w-1:0] x0;
  logic [coord_w-1:0] y0;
  logic [coord_w-1:0] x1;
  logic [coord_w-1:0] y1;
  logic [coord_w-1:0] adx;
  logic [coord_w-1:0] ady;
  logic               is_steep;
  logic [coord_w-1:0] a0;
  logic [coord_w-1:0] b0;
  logic [coord_w-1:0] a1;
  logic [coord_w-1:0] b1;
  logic [coord_w-1:0] sa;
  logic [coord_w-1:0] sb;
  logic [coord_w-1:0] ea;
  logic [coord_w-1:0] eb;
  logic               launch;

  // idle only when no launch is in flight and both later stages are empty
  assign ready  = !start && !stepper_busy && !writer_busy;
  assign launch = trigger && ready;

  // endpoints as they will be after this edge, so a strobe with the trigger counts
  assign p0_n = (ready && point0_valid) ? point : p0_q;
  assign p1_n = (ready && point1_valid) ? point : p1_q;
  assign x0   = p0_n[point_w-1 -: coord_w];
  assign y0   = p0_n[coord_w-1:0];
  assign x1   = p1_n[point_w-1 -: coord_w];
  assign y1   = p1_n[coord_w-1:0];

  always_comb begin
    adx      = (x1 >= x0) ? x1 - x0 : x0 - x1;
    ady      = (y1 >= y0) ? y1 - y0 : y0 - y1;
    is_steep = ady > adx;
    // steep lines walk along y, so swap coordinates
    a0 = is_steep ? y0 : x0;
    b0 = is_steep ? x0 : y0;
    a1 = is_steep ? y1 : x1;
    b1 = is_steep ? x1 : y1;
    // walk always runs upward in the major axis
    if (a0 > a1) begin
      sa = a1;
      sb = b1;
      ea = a0;
      eb = b0;
    end else begin
      sa = a0;
      sb = b0;
      ea = a1;
      eb = b1;
    end
  end

  always_ff @(posedge clk) begin
    if (ready) begin
      if (color_valid) begin
        pixel_color <= color;
      end
      if (point0_valid) begin
        p0_q <= point;
      end
      if (point1_valid) begin
        p1_q <= point;
      end
    end
    if (launch) begin
      steep     <= is_steep;
      x_start   <= sa;
      x_end     <= ea;
      y_start   <= sb;
      dx        <= {{(err_w - coord_w){1'b0}}, ea - sa};
      abs_dy    <= {{(err_w - coord_w){1'b0}}, (eb >= sb) ? eb - sb : sb - eb};
      y_up      <= eb >= sb;
      frame_sel <= frame_base[frame_sel_lsb +: frame_sel_w];
    end
  end

  // one-cycle start, the line fields are valid with it
  always_ff @(posedge clk) begin
    if (rst) begin
      start <= 1'b0;
    end else begin
      start <= launch;
    end
  end

endmodule

`default_nettype wire

// File: line_pkg.sv
`default_nettype none

package line_pkg;

  // endpoint geometry
  localparam int coord_w = 10;
  localparam int point_w = 2 * coord_w;

  // host words
  localparam int color_w      = 32;
  localparam int frame_base_w = 32;

  // frame select lives in frame_base[27:22]
  localparam int frame_sel_w   = 6;
  localparam int frame_sel_lsb = 22;

  // dram burst layout
  localparam int addr_w       = 31;
  localparam int data_w       = 128;
  localparam int mask_w       = 16;
  localparam int beat_pixels  = 4;
  localparam int burst_pixels = 2 * beat_pixels;
  localparam int nibble_w     = mask_w / beat_pixels;

  // pixel lane within one burst, taken from the low column bits
  localparam int lane_sel_w = $clog2(burst_pixels);

  // zero padding around the address fields
  localparam int addr_lo_w  = 2;
  localparam int addr_pad_w = addr_w - frame_sel_w - coord_w - (coord_w - lane_sel_w)
                              - addr_lo_w;

  // signed bresenham error, wide enough for err - abs_dy + dx
  localparam int err_w = 12;

endpackage

`default_nettype wire
